//--- ahb_tcm_soc.f
src/ahb_pkg.sv
src/tcm_ram.sv
src/ahb_sram_bridge.sv
src/ahb_timer.sv
src/ahb_addr_decoder.sv
src/ahb_tcm_soc.sv
bench/ahb_tcm_soc_tb.sv

//--- bench/ahb_tcm_soc_input.txt
# op addr size wdata expdata expresp (all hex), op is W write, R read, P poll irq
# P lines: wdata is the cycle limit and expdata the irq level
W 00000000 2 11223344 00000000 0
W 00000004 2 a5a5a5a5 00000000 0
R 00000004 2 00000000 a5a5a5a5 0
R 00000000 2 00000000 11223344 0
W 20000000 2 cafef00d 00000000 0
R 20000000 2 00000000 cafef00d 0
R 00000000 2 00000000 11223344 0
W 20000010 2 00000000 00000000 0
W 20000011 0 0000ab00 00000000 0
W 20000012 1 12340000 00000000 0
R 20000010 2 00000000 1234ab00 0
R 20000011 0 00000000 0000ab00 0
R 20000012 1 00000000 12340000 0
W 00000100 2 00000000 00000000 0
W 00000103 0 ef000000 00000000 0
W 00000100 1 0000beef 00000000 0
R 00000100 2 00000000 ef00beef 0
W 60000000 2 deadbeef 00000000 1
R 00000004 2 00000000 a5a5a5a5 0
R 00000800 2 00000000 00000000 1
W 40000000 2 00000005 00000000 0
W 40000008 2 00000003 00000000 0
R 40000000 2 00000000 00000005 0
R 40000008 2 00000000 00000003 0
P 00000000 2 00000009 00000001 0
W 40000008 2 00000002 00000000 0
W 4000000c 2 00000001 00000000 0
R 40000008 2 00000000 00000002 0
P 00000000 2 00000002 00000000 0

//--- bench/ahb_tcm_soc_tb.sv
module ahb_tcm_soc_tb;

    import ahb_pkg::*;

    localparam int    DRIVE_DLY = 2;
    localparam string VEC_FILE  = "bench/ahb_tcm_soc_input.txt";

    logic    clk;
    logic    arst_n;
    haddr_t  haddr;
    htrans_t htrans;
    logic    hwrite;
    hsize_t  hsize;
    hdata_t  hwdata;
    hdata_t  hrdata;
    logic    hready;
    logic    hresp;
    logic    irq;

    // One entry per transfer line of the data file
    logic [7:0] op_q[$];
    haddr_t     addr_q[$];
    hsize_t     size_q[$];
    hdata_t     wdata_q[$];
    hdata_t     exp_q[$];
    logic       resp_q[$];

    bit loaded;
    int cur_test;
    int n_errors;
    int n_pass;
    int n_fail;

    ahb_tcm_soc u_dut (
        .clk   (clk   ),
        .arst_n(arst_n),
        .haddr (haddr ),
        .htrans(htrans),
        .hwrite(hwrite),
        .hsize (hsize ),
        .hwdata(hwdata),
        .hrdata(hrdata),
        .hready(hready),
        .hresp (hresp ),
        .irq   (irq   )
    );

    always #20 clk = ~clk;

    // Active byte lanes of a narrow transfer
    function automatic hdata_t lane_mask(input hsize_t size, input logic [1:0] offs);
        case (size)
            HSIZE_BYTE: return hdata_t'(32'h0000_00FF) << (8 * offs);
            HSIZE_HALF: return offs[1] ? 32'hFFFF_0000 : 32'h0000_FFFF;
            default:    return 32'hFFFF_FFFF;
        endcase
    endfunction

    task automatic check_data(input string sig, input hdata_t got, input hdata_t exp);
        if (got !== exp) begin
            $display("** Error: test %0d %s got 0x%08h expected 0x%08h", cur_test, sig, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_resp(input string sig, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: test %0d %s got 0x%0h expected 0x%0h", cur_test, sig, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_irq(input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: test %0d irq got 0x%0h expected 0x%0h", cur_test, got, exp);
            n_errors++;
        end
    endtask

    task automatic report_test(input string what, input bit ok);
        if (ok) begin
            n_pass++;
            $display("test %0d %s passed", cur_test, what);
        end else begin
            n_fail++;
            $display("test %0d %s failed", cur_test, what);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] s;
        logic [31:0] w;
        logic [31:0] e;
        logic [31:0] r;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", VEC_FILE);
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h %h %h %h", op, a, s, w, e, r);
                    if (n == 6) begin
                        op_q.push_back(op);
                        addr_q.push_back(a);
                        size_q.push_back(hsize_t'(s));
                        wdata_q.push_back(w);
                        exp_q.push_back(e);
                        resp_q.push_back(r[0]);
                    end else begin
                        $display("A stimulus line could not be parsed: %s", line);
                        n_fail++;
                    end
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    task automatic drive_idle();
        htrans = HTRANS_IDLE;
        hwrite = 1'b0;
    endtask

    // Ends on the first edge with hready high, values taken mid-cycle before it
    task automatic complete_beat(output hdata_t rd, output logic rs);
        @(negedge clk);
        while (hready !== 1'b1) begin
            @(negedge clk);
        end
        rd = hrdata;
        rs = hresp;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_transfer(input int idx, input hdata_t rd, input logic rs);
        int     errs;
        hdata_t mask;
        errs     = n_errors;
        cur_test = idx + 1;
        mask     = lane_mask(size_q[idx], addr_q[idx][1:0]);
        check_resp("hresp", rs, resp_q[idx]);
        if (op_q[idx] == "R" && resp_q[idx] == HRESP_OKAY) begin
            check_data("hrdata", rd & mask, exp_q[idx] & mask);
        end
        report_test($sformatf("%c 0x%08h", op_q[idx], addr_q[idx]), n_errors == errs);
    endtask

    // Cycle limit in the wdata column, irq level in the expected column
    task automatic poll_irq(input int idx);
        int waited;
        int errs;
        errs     = n_errors;
        waited   = 0;
        cur_test = idx + 1;
        @(negedge clk);
        while (irq !== exp_q[idx][0] && waited < int'(wdata_q[idx])) begin
            @(negedge clk);
            waited++;
        end
        check_irq(irq, exp_q[idx][0]);
        report_test($sformatf("irq poll after %0d cycles", waited), n_errors == errs);
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic run_transfers();
        hdata_t rd;
        logic   rs;
        bit     pending;
        int     pidx;
        pending = 1'b0;
        pidx    = 0;
        for (int i = 0; i < op_q.size(); i++) begin
            if (op_q[i] == "P") begin
                drive_idle();
                if (pending) begin
                    complete_beat(rd, rs);
                    check_transfer(pidx, rd, rs);
                    pending = 1'b0;
                end
                poll_irq(i);
            end else begin
                // Address phase of i overlaps the data phase of pidx
                haddr  = addr_q[i];
                htrans = HTRANS_NONSEQ;
                hwrite = (op_q[i] == "W");
                hsize  = size_q[i];
                complete_beat(rd, rs);
                if (pending) begin
                    check_transfer(pidx, rd, rs);
                end
                hwdata  = wdata_q[i];
                pending = 1'b1;
                pidx    = i;
            end
        end
        drive_idle();
        if (pending) begin
            complete_beat(rd, rs);
            check_transfer(pidx, rd, rs);
        end
    endtask

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        haddr    = '0;
        htrans   = HTRANS_IDLE;
        hwrite   = 1'b0;
        hsize    = HSIZE_WORD;
        hwdata   = '0;
        n_errors = 0;
        n_pass   = 0;
        n_fail   = 0;
        cur_test = 0;
        load_vectors();
        if (op_q.size() == 0) begin
            $display("No transfers were read from %s", VEC_FILE);
            $display("Simulation finished: FAIL");
        end else begin
            repeat (3) @(posedge clk);
            #DRIVE_DLY;
            arst_n = 1'b1;
            @(negedge clk);
            check_resp("hready", hready, 1'b1);
            check_resp("hresp", hresp, HRESP_OKAY);
            check_irq(irq, 1'b0);
            report_test("reset values", n_errors == 0);
            @(posedge clk);
            #DRIVE_DLY;
            run_transfers();
            $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
            if (n_fail == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = 200 * op_q.size() + 1000;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired, the run did not end within %0d clock cycles", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule : ahb_tcm_soc_tb

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module ahb_tcm_soc_tb -f ahb_tcm_soc.f -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vahb_tcm_soc_tb > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation run did not complete"; }

cat sim.log 2>/dev/null
grep -qx "Simulation finished: PASS" sim.log 2>/dev/null && exit 0 || exit 1

//--- src/ahb_addr_decoder.sv
module ahb_addr_decoder (
    input  logic             clk          ,
    input  logic             arst_n       ,
    input  ahb_pkg::haddr_t  haddr        ,
    input  ahb_pkg::htrans_t htrans       ,
    input  logic             hready       ,
    output logic             hsel_itcm    ,
    output logic             hsel_dtcm    ,
    output logic             hsel_timer   ,
    input  ahb_pkg::hdata_t  itcm_rdata   ,
    input  logic             itcm_readyout,
    input  logic             itcm_resp    ,
    input  ahb_pkg::hdata_t  dtcm_rdata   ,
    input  logic             dtcm_readyout,
    input  logic             dtcm_resp    ,
    input  ahb_pkg::hdata_t  timer_rdata  ,
    input  logic             timer_readyout,
    input  logic             timer_resp   ,
    output ahb_pkg::hdata_t  hrdata       ,
    output logic             hready_out   ,
    output logic             hresp
);

    import ahb_pkg::*;

    typedef enum logic [1:0] {
        DS_IDLE,
        DS_ERR1,
        DS_ERR2
    } ds_state_t;

    ds_state_t  ds_q;
    ds_state_t  ds_d;
    logic       accept;
    logic       unmapped;
    // One-hot data-phase owner {timer, dtcm, itcm}
    logic [2:0] sel_q;

    assign hsel_itcm  = (haddr & REGION_MASK) == ITCM_BASE;
    assign hsel_dtcm  = (haddr & REGION_MASK) == DTCM_BASE;
    assign hsel_timer = (haddr & REGION_MASK) == TIMER_BASE;

    assign accept   = hready && (htrans == HTRANS_NONSEQ);
    assign unmapped = accept && !(hsel_itcm || hsel_dtcm || hsel_timer);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sel_q <= '0;
        end else if (hready) begin
            sel_q <= {3{accept}} & {hsel_timer, hsel_dtcm, hsel_itcm};
        end
    end

    // Default slave
    always_comb begin
        ds_d = ds_q;
        case (ds_q)
            DS_IDLE: begin
                if (unmapped) begin
                    ds_d = DS_ERR1;
                end
            end
            DS_ERR1: ds_d = DS_ERR2;
            DS_ERR2: ds_d = unmapped ? DS_ERR1 : DS_IDLE;
            default: ds_d = DS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ds_q <= DS_IDLE;
        end else begin
            ds_q <= ds_d;
        end
    end

    // Response mux
    always_comb begin
        hrdata     = '0;
        hready_out = 1'b1;
        hresp      = HRESP_OKAY;
        if (ds_q != DS_IDLE) begin
            hready_out = (ds_q == DS_ERR2);
            hresp      = HRESP_ERROR;
        end else begin
            case (sel_q)
                3'b001: begin
                    hrdata     = itcm_rdata;
                    hready_out = itcm_readyout;
                    hresp      = itcm_resp;
                end
                3'b010: begin
                    hrdata     = dtcm_rdata;
                    hready_out = dtcm_readyout;
                    hresp      = dtcm_resp;
                end
                3'b100: begin
                    hrdata     = timer_rdata;
                    hready_out = timer_readyout;
                    hresp      = timer_resp;
                end
                default: ;
            endcase
        end
    end

    // At most one slave owns the data phase
    assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({sel_q, ds_q != DS_IDLE}));

endmodule : ahb_addr_decoder

//--- src/ahb_pkg.sv
package ahb_pkg;

    // Bus and memory widths
    typedef logic [31:0] haddr_t;
    typedef logic [31:0] hdata_t;
    typedef logic [ 1:0] htrans_t;
    typedef logic [ 2:0] hsize_t;
    typedef logic [ 8:0] tcm_addr_t;
    typedef logic [ 3:0] byte_en_t;

    // Transfer types, only the two used by a single non-burst master
    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;

    localparam hsize_t HSIZE_BYTE = 3'b000;
    localparam hsize_t HSIZE_HALF = 3'b001;
    localparam hsize_t HSIZE_WORD = 3'b010;

    localparam logic HRESP_OKAY  = 1'b0;
    localparam logic HRESP_ERROR = 1'b1;

    // Memory map, every region is 2 KB
    localparam haddr_t REGION_MASK = 32'hFFFF_F800;
    localparam haddr_t ITCM_BASE   = 32'h0000_0000;
    localparam haddr_t DTCM_BASE   = 32'h2000_0000;
    localparam haddr_t TIMER_BASE  = 32'h4000_0000;

    // Timer register offsets
    localparam logic [7:0] TMR_LOAD   = 8'h00;
    localparam logic [7:0] TMR_VALUE  = 8'h04;
    localparam logic [7:0] TMR_CTRL   = 8'h08;
    localparam logic [7:0] TMR_INTCLR = 8'h0C;

    // Control register bits
    localparam int TMR_CTRL_EN = 0;
    localparam int TMR_CTRL_IE = 1;

endpackage : ahb_pkg

//--- src/ahb_sram_bridge.sv
module ahb_sram_bridge (
    input  logic               clk      ,
    input  logic               arst_n   ,
    input  logic               hsel     ,
    input  logic               hready   ,
    input  ahb_pkg::htrans_t   htrans   ,
    input  logic               hwrite   ,
    input  ahb_pkg::hsize_t    hsize    ,
    input  ahb_pkg::haddr_t    haddr    ,
    input  ahb_pkg::hdata_t    hwdata   ,
    output logic               hreadyout,
    output logic               hresp    ,
    output ahb_pkg::hdata_t    hrdata   ,
    output logic               ram_cs   ,
    output logic               ram_we   ,
    output ahb_pkg::tcm_addr_t ram_addr ,
    output ahb_pkg::hdata_t    ram_wdata,
    output ahb_pkg::byte_en_t  ram_be   ,
    input  ahb_pkg::hdata_t    ram_rdata
);

    import ahb_pkg::*;

    typedef enum logic [1:0] {
        BR_IDLE,
        BR_WRITE,
        BR_RD_WAIT,
        BR_RD_DATA
    } br_state_t;

    br_state_t  state_q;
    br_state_t  state_d;
    logic       accept;
    tcm_addr_t  word_q;
    logic [1:0] lane_q;
    hsize_t     size_q;
    byte_en_t   lanes;

    assign accept = hsel && hready && (htrans == HTRANS_NONSEQ);

    // Direction is carried by the state itself
    always_comb begin
        state_d = state_q;
        case (state_q)
            BR_RD_WAIT: state_d = BR_RD_DATA;
            default: begin
                if (accept) begin
                    state_d = hwrite ? BR_WRITE : BR_RD_WAIT;
                end else begin
                    state_d = BR_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= BR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            word_q <= haddr[10:2];
            lane_q <= haddr[1:0];
            size_q <= hsize;
        end
    end

    always_comb begin
        case (size_q)
            HSIZE_BYTE: lanes = byte_en_t'(4'b0001 << lane_q);
            HSIZE_HALF: lanes = lane_q[1] ? 4'b1100 : 4'b0011;
            HSIZE_WORD: lanes = 4'b1111;
            default:    lanes = 4'b0000;
        endcase
    end

    // RAM is strobed only in data phases
    assign ram_cs    = (state_q == BR_WRITE) || (state_q == BR_RD_WAIT);
    assign ram_we    = (state_q == BR_WRITE);
    assign ram_addr  = word_q;
    assign ram_wdata = hwdata;
    assign ram_be    = lanes;

    assign hreadyout = (state_q != BR_RD_WAIT);
    assign hresp     = HRESP_OKAY;
    assign hrdata    = (state_q == BR_RD_DATA) ? ram_rdata : '0;

    // The read wait state stalls the whole bus
    assert property (@(posedge clk) disable iff (!arst_n) !hreadyout |-> !hready);

endmodule : ahb_sram_bridge

//--- src/ahb_tcm_soc.sv
module ahb_tcm_soc (
    input  logic             clk   ,
    input  logic             arst_n,
    input  ahb_pkg::haddr_t  haddr ,
    input  ahb_pkg::htrans_t htrans,
    input  logic             hwrite,
    input  ahb_pkg::hsize_t  hsize ,
    input  ahb_pkg::hdata_t  hwdata,
    output ahb_pkg::hdata_t  hrdata,
    output logic             hready,
    output logic             hresp ,
    output logic             irq
);

    import ahb_pkg::*;

    logic      hsel_itcm;
    logic      hsel_dtcm;
    logic      hsel_timer;

    // Slave responses
    hdata_t    itcm_hrdata;
    logic      itcm_hreadyout;
    logic      itcm_hresp;
    hdata_t    dtcm_hrdata;
    logic      dtcm_hreadyout;
    logic      dtcm_hresp;
    hdata_t    timer_hrdata;
    logic      timer_hreadyout;
    logic      timer_hresp;

    // RAM ports
    logic      itcm_cs;
    logic      itcm_we;
    tcm_addr_t itcm_addr;
    hdata_t    itcm_wdata;
    byte_en_t  itcm_be;
    hdata_t    itcm_rdata;
    logic      dtcm_cs;
    logic      dtcm_we;
    tcm_addr_t dtcm_addr;
    hdata_t    dtcm_wdata;
    byte_en_t  dtcm_be;
    hdata_t    dtcm_rdata;

    ahb_addr_decoder u_addr_decoder (
        .clk           (clk            ),
        .arst_n        (arst_n         ),
        .haddr         (haddr          ),
        .htrans        (htrans         ),
        .hready        (hready         ),
        .hsel_itcm     (hsel_itcm      ),
        .hsel_dtcm     (hsel_dtcm      ),
        .hsel_timer    (hsel_timer     ),
        .itcm_rdata    (itcm_hrdata    ),
        .itcm_readyout (itcm_hreadyout ),
        .itcm_resp     (itcm_hresp     ),
        .dtcm_rdata    (dtcm_hrdata    ),
        .dtcm_readyout (dtcm_hreadyout ),
        .dtcm_resp     (dtcm_hresp     ),
        .timer_rdata   (timer_hrdata   ),
        .timer_readyout(timer_hreadyout),
        .timer_resp    (timer_hresp    ),
        .hrdata        (hrdata         ),
        .hready_out    (hready         ),
        .hresp         (hresp          )
    );

    ahb_sram_bridge u_itcm_bridge (
        .clk      (clk           ),
        .arst_n   (arst_n        ),
        .hsel     (hsel_itcm     ),
        .hready   (hready        ),
        .htrans   (htrans        ),
        .hwrite   (hwrite        ),
        .hsize    (hsize         ),
        .haddr    (haddr         ),
        .hwdata   (hwdata        ),
        .hreadyout(itcm_hreadyout),
        .hresp    (itcm_hresp    ),
        .hrdata   (itcm_hrdata   ),
        .ram_cs   (itcm_cs       ),
        .ram_we   (itcm_we       ),
        .ram_addr (itcm_addr     ),
        .ram_wdata(itcm_wdata    ),
        .ram_be   (itcm_be       ),
        .ram_rdata(itcm_rdata    )
    );

    // 512 words, 2 KB
    tcm_ram u_itcm (
        .clk  (clk       ),
        .cs   (itcm_cs   ),
        .we   (itcm_we   ),
        .addr (itcm_addr ),
        .wdata(itcm_wdata),
        .be   (itcm_be   ),
        .rdata(itcm_rdata)
    );

    ahb_sram_bridge u_dtcm_bridge (
        .clk      (clk           ),
        .arst_n   (arst_n        ),
        .hsel     (hsel_dtcm     ),
        .hready   (hready        ),
        .htrans   (htrans        ),
        .hwrite   (hwrite        ),
        .hsize    (hsize         ),
        .haddr    (haddr         ),
        .hwdata   (hwdata        ),
        .hreadyout(dtcm_hreadyout),
        .hresp    (dtcm_hresp    ),
        .hrdata   (dtcm_hrdata   ),
        .ram_cs   (dtcm_cs       ),
        .ram_we   (dtcm_we       ),
        .ram_addr (dtcm_addr     ),
        .ram_wdata(dtcm_wdata    ),
        .ram_be   (dtcm_be       ),
        .ram_rdata(dtcm_rdata    )
    );

    tcm_ram u_dtcm (
        .clk  (clk       ),
        .cs   (dtcm_cs   ),
        .we   (dtcm_we   ),
        .addr (dtcm_addr ),
        .wdata(dtcm_wdata),
        .be   (dtcm_be   ),
        .rdata(dtcm_rdata)
    );

    ahb_timer u_timer (
        .clk      (clk            ),
        .arst_n   (arst_n         ),
        .hsel     (hsel_timer     ),
        .hready   (hready         ),
        .htrans   (htrans         ),
        .hwrite   (hwrite         ),
        .haddr    (haddr          ),
        .hwdata   (hwdata         ),
        .hreadyout(timer_hreadyout),
        .hresp    (timer_hresp    ),
        .hrdata   (timer_hrdata   ),
        .irq      (irq            )
    );

endmodule : ahb_tcm_soc

//--- src/ahb_timer.sv
module ahb_timer (
    input  logic             clk      ,
    input  logic             arst_n   ,
    input  logic             hsel     ,
    input  logic             hready   ,
    input  ahb_pkg::htrans_t htrans   ,
    input  logic             hwrite   ,
    input  ahb_pkg::haddr_t  haddr    ,
    input  ahb_pkg::hdata_t  hwdata   ,
    output logic             hreadyout,
    output logic             hresp    ,
    output ahb_pkg::hdata_t  hrdata   ,
    output logic             irq
);

    import ahb_pkg::*;

    logic       dphase_q;
    logic       write_q;
    logic [7:0] offset_q;
    hdata_t     load_q;
    hdata_t     value_q;
    logic [1:0] ctrl_q;
    logic       flag_q;
    logic       wr_en;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dphase_q <= 1'b0;
        end else if (hready) begin
            dphase_q <= hsel && (htrans == HTRANS_NONSEQ);
        end
    end

    always_ff @(posedge clk) begin
        if (hready && hsel) begin
            write_q  <= hwrite;
            offset_q <= haddr[7:0];
        end
    end

    assign wr_en = dphase_q && write_q && hready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_q  <= '0;
            value_q <= '0;
            ctrl_q  <= '0;
            flag_q  <= 1'b0;
        end else begin
            if (wr_en && (offset_q == TMR_CTRL)) begin
                ctrl_q <= hwdata[1:0];
            end
            // A load write restarts the count
            if (wr_en && (offset_q == TMR_LOAD)) begin
                load_q  <= hwdata;
                value_q <= hwdata;
            end else if (ctrl_q[TMR_CTRL_EN]) begin
                if (value_q == '0) begin
                    value_q <= load_q;
                    flag_q  <= 1'b1;
                end else begin
                    value_q <= value_q - 1'b1;
                end
            end
            // Clear wins over a reload in the same cycle
            if (wr_en && (offset_q == TMR_INTCLR)) begin
                flag_q <= 1'b0;
            end
        end
    end

    always_comb begin
        hrdata = '0;
        if (dphase_q && !write_q) begin
            case (offset_q)
                TMR_LOAD:   hrdata = load_q;
                TMR_VALUE:  hrdata = value_q;
                TMR_CTRL:   hrdata = hdata_t'(ctrl_q);
                TMR_INTCLR: hrdata = hdata_t'(flag_q);
                default:    ;
            endcase
        end
    end

    assign hreadyout = 1'b1;
    assign hresp     = HRESP_OKAY;
    assign irq       = flag_q && ctrl_q[TMR_CTRL_IE];

    // Timer data phases complete without wait states
    assert property (@(posedge clk) disable iff (!arst_n) dphase_q |-> hready);

endmodule : ahb_timer

//--- src/tcm_ram.sv
module tcm_ram (
    input  logic               clk  ,
    input  logic               cs   ,
    input  logic               we   ,
    input  ahb_pkg::tcm_addr_t addr ,
    input  ahb_pkg::hdata_t    wdata,
    input  ahb_pkg::byte_en_t  be   ,
    output ahb_pkg::hdata_t    rdata
);

    import ahb_pkg::*;

    hdata_t mem [2**$bits(tcm_addr_t)];

    // Registered read, byte-masked write
    always_ff @(posedge clk) begin
        if (cs) begin
            if (we) begin
                for (int i = 0; i < $bits(byte_en_t); i++) begin
                    if (be[i]) begin
                        mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule : tcm_ram
